// ==== sources.f ====
logic/rs_isa_pkg.sv
logic/rs_cfg_pkg.sv
logic/rs_control.sv
logic/rs_payload_store.sv
logic/rs_operand_capture.sv
logic/alu_unit.sv
logic/rs_subsystem.sv
testbench/rs_subsystem_checker.sv
testbench/rs_subsystem_tb.sv

// ==== Makefile ====
# Verilator build and run of the reservation station testbench.
# Any variable below can be overridden on the command line.
VERILATOR ?= verilator
TOP       ?= rs_subsystem_tb
FLIST     ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  build  only compile the testbench and RTL"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

test: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/rs_subsystem_tb.sv ====
// Directed testbench for the reservation station issue block.
// Inputs change 1 ns after the rising edge, and outputs are sampled there.
// Expected results come from a reference model of the opcode rules.
// A CDB broadcast is never driven in the dispatch cycle of its consumer.
`timescale 1ns/1ps
`default_nettype none

module rs_subsystem_tb;

    import rs_isa_pkg::*;
    import rs_cfg_pkg::*;

    // The tests take about 150 cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;
    // Longest wait for one result before it counts as missing
    localparam int RESULT_WAIT = 20;

    logic    clk;
    logic    n_rst;
    logic    disp_en;
    opcode_t disp_opcode;
    tag_t    disp_dst_tag;
    logic    disp_src_rdy_a;
    data_t   disp_src_a;
    tag_t    disp_src_tag_a;
    logic    disp_src_rdy_b;
    data_t   disp_src_b;
    tag_t    disp_src_tag_b;
    logic    disp_stall;
    logic    cdb_en;
    tag_t    cdb_tag;
    data_t   cdb_data;
    logic    flush;
    logic    result_valid;
    tag_t    result_tag;
    data_t   result_data;
    logic    result_stall;

    int      error_count = 0;
    int      check_count = 0;
    int      test_count = 0;
    int      test_errors = 0;
    int      cycle_count = 0;
    integer  seed = 67;
    // Results still owed by the DUT, oldest first
    tag_t    exp_tags [$];
    data_t   exp_data [$];

    rs_subsystem dut_i (.*);

    bind rs_control rs_subsystem_checker checker_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .flush        (flush),
        .disp_en      (disp_en),
        .issue_sel    (issue_sel),
        .dispatch_sel (dispatch_sel),
        .disp_stall   (disp_stall)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run stopped making progress", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic data_t model_alu(opcode_t op, data_t a, data_t b);
        data_t r;
        case (op)
            OP_ADD: r = a + b;
            OP_SUB: r = a - b;
            OP_AND: r = a & b;
            OP_OR:  r = a | b;
            OP_XOR: r = a ^ b;
            OP_SLT: begin
                // Different signs are decided by the sign of a alone
                if (a[DATA_WIDTH-1] != b[DATA_WIDTH-1]) begin
                    r = data_t'(a[DATA_WIDTH-1]);
                end else begin
                    r = data_t'(a < b);
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic check_data(string name, data_t actual, data_t expected);
        check_count++;
        if (actual !== expected) begin
            $display("CHECK FAILED t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_tag(string name, tag_t actual, tag_t expected);
        check_count++;
        if (actual !== expected) begin
            $display("CHECK FAILED t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_bit(string name, logic actual, logic expected);
        check_count++;
        if (actual !== expected) begin
            $display("CHECK FAILED t=%0t %s: got %b, expected %b", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_dispatch(opcode_t op, tag_t dst, logic rdy_a, data_t a, tag_t tag_a,
                                  logic rdy_b, data_t b, tag_t tag_b);
        disp_en        = 1'b1;
        disp_opcode    = op;
        disp_dst_tag   = dst;
        disp_src_rdy_a = rdy_a;
        disp_src_a     = a;
        disp_src_tag_a = tag_a;
        disp_src_rdy_b = rdy_b;
        disp_src_b     = b;
        disp_src_tag_b = tag_b;
        next_cycle();
        disp_en = 1'b0;
    endtask

    task automatic broadcast(tag_t tag, data_t data);
        cdb_en   = 1'b1;
        cdb_tag  = tag;
        cdb_data = data;
        next_cycle();
        cdb_en = 1'b0;
    endtask

    task automatic push_expected(tag_t tag, data_t data);
        exp_tags.push_back(tag);
        exp_data.push_back(data);
    endtask

    // Waits for the next result, compares it with the oldest owed one, and
    // lets it leave at the following edge
    task automatic wait_result();
        int    waited;
        tag_t  tag;
        data_t data;
        waited = 0;
        tag    = exp_tags.pop_front();
        data   = exp_data.pop_front();
        while (!result_valid && waited < RESULT_WAIT) begin
            next_cycle();
            waited++;
        end
        if (!result_valid) begin
            $display("No result with tag %h arrived within %0d cycles at t=%0t",
                     tag, RESULT_WAIT, $time);
            error_count++;
        end else begin
            check_tag("result_tag", result_tag, tag);
            check_data("result_data", result_data, data);
            next_cycle();
        end
    endtask

    task automatic drain_results();
        while (exp_tags.size() > 0) begin
            wait_result();
        end
    endtask

    task automatic expect_idle(int cycles);
        for (int i = 0; i < cycles; i++) begin
            check_bit("result_valid idle", result_valid, 1'b0);
            next_cycle();
        end
    endtask

    task automatic finish_test(string name);
        test_count++;
        $display("Test %s finished with %0d errors", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    task automatic test_ready_ops();
        opcode_t op;
        data_t   a;
        data_t   b;
        tag_t    dst;
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 6; k++) begin
                op  = opcode_t'(k);
                a   = data_t'($random(seed));
                b   = data_t'($random(seed));
                dst = tag_t'(round * 6 + k);
                drive_dispatch(op, dst, 1'b1, a, '0, 1'b1, b, '0);
                // Issue happens at the next edge and the result appears after it
                check_bit("result_valid early", result_valid, 1'b0);
                next_cycle();
                check_bit("result_valid", result_valid, 1'b1);
                check_tag("result_tag", result_tag, dst);
                check_data("result_data", result_data, model_alu(op, a, b));
            end
        end
        next_cycle();
        finish_test("ready_ops");
    endtask

    task automatic test_oldest_first();
        data_t vals [4];
        data_t b;
        b = data_t'($random(seed));
        result_stall = 1'b1;
        for (int i = 0; i < 4; i++) begin
            vals[i] = data_t'($random(seed));
            drive_dispatch(OP_SUB, tag_t'(20 + i), 1'b0, '0, tag_t'(10 + i), 1'b1, b, '0);
        end
        // The youngest wakes first and its held result blocks issue while
        // the three older ones wake one after another
        for (int i = 3; i >= 0; i--) begin
            broadcast(tag_t'(10 + i), vals[i]);
        end
        check_bit("result_valid held", result_valid, 1'b1);
        check_tag("result_tag held", result_tag, tag_t'(23));
        push_expected(tag_t'(23), model_alu(OP_SUB, vals[3], b));
        for (int i = 0; i < 3; i++) begin
            push_expected(tag_t'(20 + i), model_alu(OP_SUB, vals[i], b));
        end
        result_stall = 1'b0;
        drain_results();
        expect_idle(2);
        finish_test("oldest_first");
    endtask

    task automatic test_cdb_capture();
        data_t keep_a;
        data_t keep_b;
        data_t bus;
        keep_a = data_t'($random(seed));
        keep_b = data_t'($random(seed));
        bus    = data_t'($random(seed));
        // Both sources of both slots carry tag 30, but only one source per slot waits
        drive_dispatch(OP_SUB, tag_t'(40), 1'b0, '0, tag_t'(30), 1'b1, keep_b, tag_t'(30));
        drive_dispatch(OP_SUB, tag_t'(41), 1'b1, keep_a, tag_t'(30), 1'b0, '0, tag_t'(30));
        push_expected(tag_t'(40), model_alu(OP_SUB, bus, keep_b));
        push_expected(tag_t'(41), model_alu(OP_SUB, keep_a, bus));
        expect_idle(1);
        broadcast(tag_t'(30), bus);
        drain_results();
        // Nothing waits on tag 30 any more
        broadcast(tag_t'(30), ~bus);
        expect_idle(2);
        finish_test("cdb_capture");
    endtask

    task automatic test_full_backpressure();
        data_t vals [RS_DEPTH];
        data_t bus;
        bus = data_t'($random(seed));
        result_stall = 1'b1;
        // Every slot waits on tag 50 for source B, so nothing issues while filling
        for (int i = 0; i < RS_DEPTH; i++) begin
            check_bit("disp_stall before full", disp_stall, 1'b0);
            vals[i] = data_t'($random(seed));
            drive_dispatch(opcode_t'(i % 6), tag_t'(i), 1'b1, vals[i], '0, 1'b0, '0, tag_t'(50));
            push_expected(tag_t'(i), model_alu(opcode_t'(i % 6), vals[i], bus));
        end
        check_bit("disp_stall when full", disp_stall, 1'b1);
        // If this one were taken, tag 63 would break the drain order below
        drive_dispatch(OP_ADD, tag_t'(63), 1'b1, '0, '0, 1'b1, '0, '0);
        check_bit("disp_stall after ignored dispatch", disp_stall, 1'b1);
        broadcast(tag_t'(50), bus);
        next_cycle();
        check_bit("result_valid under stall", result_valid, 1'b1);
        check_tag("result_tag under stall", result_tag, tag_t'(0));
        result_stall = 1'b0;
        drain_results();
        check_bit("disp_stall after drain", disp_stall, 1'b0);
        expect_idle(2);
        finish_test("full_backpressure");
    endtask

    task automatic test_flush();
        result_stall = 1'b1;
        drive_dispatch(OP_ADD, tag_t'(5), 1'b1, data_t'(7), '0, 1'b1, data_t'(9), '0);
        // The ADD issues and is held, then waiting XORs fill every slot
        for (int i = 0; i < RS_DEPTH; i++) begin
            drive_dispatch(OP_XOR, tag_t'(10 + i), 1'b0, '0, tag_t'(50 + i), 1'b1, '0, '0);
        end
        check_bit("result_valid before flush", result_valid, 1'b1);
        check_bit("disp_stall before flush", disp_stall, 1'b1);
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        result_stall = 1'b0;
        check_bit("result_valid after flush", result_valid, 1'b0);
        check_bit("disp_stall after flush", disp_stall, 1'b0);
        // A woken slot would show its result one edge after the next broadcast
        for (int i = 0; i < RS_DEPTH; i++) begin
            broadcast(tag_t'(50 + i), data_t'($random(seed)));
            check_bit("result_valid after broadcast", result_valid, 1'b0);
        end
        expect_idle(2);
        // A ready dispatch in a flush cycle is dropped and never issues
        flush = 1'b1;
        drive_dispatch(OP_OR, tag_t'(15), 1'b1, '0, '0, 1'b1, '0, '0);
        flush = 1'b0;
        expect_idle(3);
        finish_test("flush");
    endtask

    initial begin
        clk            = 1'b0;
        n_rst          = 1'b0;
        disp_en        = 1'b0;
        disp_opcode    = OP_ADD;
        disp_dst_tag   = '0;
        disp_src_rdy_a = 1'b0;
        disp_src_a     = '0;
        disp_src_tag_a = '0;
        disp_src_rdy_b = 1'b0;
        disp_src_b     = '0;
        disp_src_tag_b = '0;
        cdb_en         = 1'b0;
        cdb_tag        = '0;
        cdb_data       = '0;
        flush          = 1'b0;
        result_stall   = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        n_rst = 1'b1;
        check_bit("disp_stall after reset", disp_stall, 1'b0);
        check_bit("result_valid after reset", result_valid, 1'b0);
        next_cycle();
        test_ready_ops();
        test_oldest_first();
        test_cdb_capture();
        test_full_backpressure();
        test_flush();
        // Assertion failures in the bound checker count as errors too
        error_count += dut_i.control_i.checker_i.failures;
        $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/rs_subsystem_checker.sv ====
// Concurrent assertions on the reservation station controller, bound into
// rs_control. Occupancy is counted here from the selection vectors alone.
`timescale 1ns/1ps
`default_nettype none

module rs_subsystem_checker (
    input logic                  clk,
    input logic                  n_rst,
    input logic                  flush,
    input logic                  disp_en,
    input rs_cfg_pkg::slot_vec_t issue_sel,
    input rs_cfg_pkg::slot_vec_t dispatch_sel,
    input logic                  disp_stall
);

    import rs_cfg_pkg::*;

    // Number of assertion failures so far
    int failures = 0;
    // Slots in use, as seen from the fills and issues
    int occupied;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            occupied <= 0;
        end else if (flush) begin
            occupied <= 0;
        end else begin
            occupied <= occupied + $countones(dispatch_sel) - $countones(issue_sel);
        end
    end

    // At most one slot leaves the station per cycle
    issue_onehot: assert property (@(posedge clk) disable iff (!n_rst)
        $onehot0(issue_sel))
        else begin
            $error("issue_sel selects more than one slot");
            failures++;
        end

    // A taken dispatch fills exactly one slot and any other cycle fills none
    dispatch_onehot: assert property (@(posedge clk) disable iff (!n_rst)
        (disp_en && !disp_stall && !flush) ? $onehot(dispatch_sel) : (dispatch_sel == '0))
        else begin
            $error("dispatch_sel does not match the dispatch request");
            failures++;
        end

    // The stall level is high exactly when every slot is counted as occupied
    stall_when_full: assert property (@(posedge clk) disable iff (!n_rst)
        disp_stall == (occupied == RS_DEPTH))
        else begin
            $error("disp_stall does not match slot occupancy");
            failures++;
        end

endmodule

`default_nettype wire

// ==== logic/rs_subsystem.sv ====
// Issue block for one ALU: eight-slot reservation station and a registered
// ALU. No renaming and no CDB arbitration. The CDB is a plain input and the
// result a plain output. A CDB broadcast in the dispatch cycle of its
// consumer is missed.
`timescale 1ns/1ps
`default_nettype none

module rs_subsystem (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                disp_en,
    input  rs_isa_pkg::opcode_t disp_opcode,
    input  rs_cfg_pkg::tag_t    disp_dst_tag,
    input  logic                disp_src_rdy_a,
    input  rs_isa_pkg::data_t   disp_src_a,
    input  rs_cfg_pkg::tag_t    disp_src_tag_a,
    input  logic                disp_src_rdy_b,
    input  rs_isa_pkg::data_t   disp_src_b,
    input  rs_cfg_pkg::tag_t    disp_src_tag_b,
    output logic                disp_stall,
    input  logic                cdb_en,
    input  rs_cfg_pkg::tag_t    cdb_tag,
    input  rs_isa_pkg::data_t   cdb_data,
    input  logic                flush,
    output logic                result_valid,
    output rs_cfg_pkg::tag_t    result_tag,
    output rs_isa_pkg::data_t   result_data,
    input  logic                result_stall
);

    import rs_isa_pkg::*;
    import rs_cfg_pkg::*;

    slot_vec_t   dispatch_sel;
    slot_idx_t   issue_slot;
    logic        issue_valid;
    logic        fu_stall;
    slot_vec_t   src_rdy_a;
    slot_vec_t   src_rdy_b;
    opcode_t     iss_opcode;
    tag_t        iss_dst_tag;
    data_t       iss_src_a;
    data_t       iss_src_b;
    // Element 0 is source A and element 1 is source B
    tag_t [1:0]  src_tag_entries [RS_DEPTH];
    tag_t        src_tags_a [RS_DEPTH];
    tag_t        src_tags_b [RS_DEPTH];

    rs_control control_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .flush        (flush),
        .disp_en      (disp_en),
        .fu_stall     (fu_stall),
        .src_rdy_a    (src_rdy_a),
        .src_rdy_b    (src_rdy_b),
        .disp_stall   (disp_stall),
        .dispatch_sel (dispatch_sel),
        .issue_sel    (),
        .issue_slot   (issue_slot),
        .issue_valid  (issue_valid)
    );

    rs_payload_store #(.payload_t(opcode_t)) opcode_store_i (
        .clk          (clk),
        .dispatch_sel (dispatch_sel),
        .wr_data      (disp_opcode),
        .issue_slot   (issue_slot),
        .rd_data      (iss_opcode),
        .entries      ()
    );

    rs_payload_store #(.payload_t(tag_t)) dst_tag_store_i (
        .clk          (clk),
        .dispatch_sel (dispatch_sel),
        .wr_data      (disp_dst_tag),
        .issue_slot   (issue_slot),
        .rd_data      (iss_dst_tag),
        .entries      ()
    );

    // Source tags are only needed per slot for the CDB compare, so the
    // issue-side read of this store stays open
    rs_payload_store #(.payload_t(tag_t [1:0])) src_tag_store_i (
        .clk          (clk),
        .dispatch_sel (dispatch_sel),
        .wr_data      ({disp_src_tag_b, disp_src_tag_a}),
        .issue_slot   (issue_slot),
        .rd_data      (),
        .entries      (src_tag_entries)
    );

    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_src_tags
        assign src_tags_a[i] = src_tag_entries[i][0];
        assign src_tags_b[i] = src_tag_entries[i][1];
    end

    rs_operand_capture src_a_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .flush        (flush),
        .dispatch_sel (dispatch_sel),
        .disp_rdy     (disp_src_rdy_a),
        .disp_data    (disp_src_a),
        .src_tags     (src_tags_a),
        .cdb_en       (cdb_en),
        .cdb_tag      (cdb_tag),
        .cdb_data     (cdb_data),
        .issue_slot   (issue_slot),
        .rdy          (src_rdy_a),
        .rd_data      (iss_src_a)
    );

    rs_operand_capture src_b_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .flush        (flush),
        .dispatch_sel (dispatch_sel),
        .disp_rdy     (disp_src_rdy_b),
        .disp_data    (disp_src_b),
        .src_tags     (src_tags_b),
        .cdb_en       (cdb_en),
        .cdb_tag      (cdb_tag),
        .cdb_data     (cdb_data),
        .issue_slot   (issue_slot),
        .rdy          (src_rdy_b),
        .rd_data      (iss_src_b)
    );

    alu_unit alu_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .opcode       (iss_opcode),
        .src_a        (iss_src_a),
        .src_b        (iss_src_b),
        .dst_tag      (iss_dst_tag),
        .result_stall (result_stall),
        .fu_stall     (fu_stall),
        .result_valid (result_valid),
        .result_tag   (result_tag),
        .result_data  (result_data)
    );

endmodule

`default_nettype wire

// ==== logic/alu_unit.sv ====
// Single-stage ALU with a registered result.
// A result is held while result_stall is high, and fu_stall then blocks
// issue. Unused opcodes give zero.
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                flush,
    input  logic                issue_valid,
    input  rs_isa_pkg::opcode_t opcode,
    input  rs_isa_pkg::data_t   src_a,
    input  rs_isa_pkg::data_t   src_b,
    input  rs_cfg_pkg::tag_t    dst_tag,
    input  logic                result_stall,
    output logic                fu_stall,
    output logic                result_valid,
    output rs_cfg_pkg::tag_t    result_tag,
    output rs_isa_pkg::data_t   result_data
);

    import rs_isa_pkg::*;

    data_t alu_out;

    always_comb begin
        case (opcode)
            OP_ADD:  alu_out = src_a + src_b;
            OP_SUB:  alu_out = src_a - src_b;
            OP_AND:  alu_out = src_a & src_b;
            OP_OR:   alu_out = src_a | src_b;
            OP_XOR:  alu_out = src_a ^ src_b;
            // Signed compare, zero-extended to a full word
            OP_SLT:  alu_out = data_t'($signed(src_a) < $signed(src_b));
            default: alu_out = '0;
        endcase
    end

    // Blocking only matters while a result is actually waiting
    assign fu_stall = result_valid & result_stall;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            result_valid <= 1'b0;
        end else if (flush) begin
            result_valid <= 1'b0;
        end else if (!fu_stall) begin
            result_valid <= issue_valid;
        end
    end

    // issue_valid is never high under fu_stall, so this load cannot
    // overwrite a held result
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            result_tag  <= dst_tag;
            result_data <= alu_out;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rs_operand_capture.sv ====
// One source operand per slot, with wake-up from the common data bus.
// A broadcast in the same cycle that dispatches its consumer is missed.
// Ready flags say nothing about occupancy, which the controller owns.
`timescale 1ns/1ps
`default_nettype none

module rs_operand_capture (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  flush,
    input  rs_cfg_pkg::slot_vec_t dispatch_sel,
    input  logic                  disp_rdy,
    input  rs_isa_pkg::data_t     disp_data,
    input  rs_cfg_pkg::tag_t      src_tags [rs_cfg_pkg::RS_DEPTH],
    input  logic                  cdb_en,
    input  rs_cfg_pkg::tag_t      cdb_tag,
    input  rs_isa_pkg::data_t     cdb_data,
    input  rs_cfg_pkg::slot_idx_t issue_slot,
    output rs_cfg_pkg::slot_vec_t rdy,
    output rs_isa_pkg::data_t     rd_data
);

    import rs_isa_pkg::*;
    import rs_cfg_pkg::*;

    data_t     value [RS_DEPTH];
    slot_vec_t cdb_hit;

    // Only operands still waiting may match. A ready operand keeps its
    // value even when its stale tag is broadcast again
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            cdb_hit[i] = cdb_en && !rdy[i] && (src_tags[i] == cdb_tag);
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            rdy <= '0;
        end else if (flush) begin
            rdy <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (dispatch_sel[i]) begin
                    rdy[i] <= disp_rdy;
                end else if (cdb_hit[i]) begin
                    rdy[i] <= 1'b1;
                end
            end
        end
    end

    // Operand values load with their flags but need no reset
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (dispatch_sel[i]) begin
                value[i] <= disp_data;
            end else if (cdb_hit[i]) begin
                value[i] <= cdb_data;
            end
        end
    end

    assign rd_data = value[issue_slot];

endmodule

`default_nettype wire

// ==== logic/rs_payload_store.sv ====
// Per-slot store for one dispatched field. No reset, since occupancy in the
// controller decides whether a slot's content means anything.
// The read at the issue slot is combinational.
`timescale 1ns/1ps
`default_nettype none

module rs_payload_store #(
    parameter type payload_t = logic
) (
    input  logic                  clk,
    input  rs_cfg_pkg::slot_vec_t dispatch_sel,
    input  payload_t              wr_data,
    input  rs_cfg_pkg::slot_idx_t issue_slot,
    output payload_t              rd_data,
    output payload_t              entries [rs_cfg_pkg::RS_DEPTH]
);

    import rs_cfg_pkg::*;

    // dispatch_sel is already masked by a real dispatch, so at most one
    // slot loads per cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (dispatch_sel[i]) begin
                entries[i] <= wr_data;
            end
        end
    end

    assign rd_data = entries[issue_slot];

endmodule

`default_nettype wire

// ==== logic/rs_control.sv ====
// Reservation station controller. Holds occupancy and ages and makes the
// issue and dispatch choices. A dispatch in a flush cycle is dropped.
// Ages of empty slots are meaningless and may wrap.
`timescale 1ns/1ps
`default_nettype none

module rs_control (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  flush,
    input  logic                  disp_en,
    input  logic                  fu_stall,
    input  rs_cfg_pkg::slot_vec_t src_rdy_a,
    input  rs_cfg_pkg::slot_vec_t src_rdy_b,
    output logic                  disp_stall,
    output rs_cfg_pkg::slot_vec_t dispatch_sel,
    output rs_cfg_pkg::slot_vec_t issue_sel,
    output rs_cfg_pkg::slot_idx_t issue_slot,
    output logic                  issue_valid
);

    import rs_cfg_pkg::*;

    slot_vec_t empty;
    slot_idx_t age [RS_DEPTH];
    slot_vec_t older [RS_DEPTH];
    slot_vec_t issue_ready;
    slot_vec_t issue_pick;
    slot_vec_t free_pick;
    slot_idx_t issue_age;
    logic      dispatching;
    logic      issuing;

    // Row i of the age matrix marks every slot that slot i is older than.
    // The diagonal is set so that a slot never blocks itself
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int j = 0; j < RS_DEPTH; j++) begin
                older[i][j] = (i == j) || (age[i] > age[j]);
            end
        end
    end

    // A slot may issue once it is occupied and both operands are ready
    assign issue_ready = ~empty & src_rdy_a & src_rdy_b;

    // Comparisons against slots that cannot issue are forced true,
    // which leaves only the oldest ready slot with a full row
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            issue_pick[i] = issue_ready[i] & (&(older[i] | ~issue_ready));
        end
    end

    // Lowest empty slot as a one-hot vector
    assign free_pick  = empty & ~(empty - 1'b1);
    assign disp_stall = ~|empty;

    assign dispatching = disp_en & ~disp_stall & ~flush;
    // An issue in a flush cycle would be discarded by the ALU anyway
    assign issuing     = (|issue_pick) & ~fu_stall & ~flush;

    assign dispatch_sel = free_pick & {RS_DEPTH{dispatching}};
    assign issue_sel    = issue_pick & {RS_DEPTH{issuing}};
    assign issue_valid  = issuing;

    // One-hot to binary. The index stays valid even when nothing issues,
    // so the datapath reads a stable slot
    always_comb begin
        issue_slot = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (issue_pick[i]) begin
                issue_slot = issue_slot | slot_idx_t'(i);
            end
        end
    end

    assign issue_age = age[issue_slot];

    // Dispatch and issue never touch the same slot, since one picks an
    // empty slot and the other an occupied one
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            empty <= '1;
        end else if (flush) begin
            empty <= '1;
        end else begin
            empty <= (empty | issue_sel) & ~dispatch_sel;
        end
    end

    // The new slot starts at age 0.
    // Dispatch alone ages every other slot by one.
    // Issue alone closes the gap above the issued slot.
    // With both, only slots younger than the issued one move up
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (dispatch_sel[i]) begin
                    age[i] <= '0;
                end else if (dispatching && !issuing) begin
                    age[i] <= age[i] + 1'b1;
                end else if (issuing && !dispatching && (age[i] > issue_age)) begin
                    age[i] <= age[i] - 1'b1;
                end else if (issuing && dispatching && (age[i] < issue_age)) begin
                    age[i] <= age[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/rs_cfg_pkg.sv ====
// Reservation station geometry.
// RS_DEPTH must be a power of two, so that an age fits in a slot index.
`default_nettype none

package rs_cfg_pkg;

    localparam int RS_DEPTH  = 8;
    localparam int TAG_WIDTH = 6;

    // Slot indices and ages share this width
    localparam int SLOT_IDX_WIDTH = $clog2(RS_DEPTH);

    typedef logic [TAG_WIDTH-1:0]      tag_t;
    typedef logic [SLOT_IDX_WIDTH-1:0] slot_idx_t;

    // One bit per slot
    typedef logic [RS_DEPTH-1:0] slot_vec_t;

endpackage

`default_nettype wire

// ==== logic/rs_isa_pkg.sv ====
// Operation encoding and data width for the arithmetic functional unit.
// Only register-register integer operations exist. There is no immediate
// form and no instruction word.
`default_nettype none

package rs_isa_pkg;

    // Operands and results share one width
    localparam int DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // The encoding is dense from zero, and codes 6 and 7 are unused
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLT = 3'd5
    } opcode_t;

endpackage

`default_nettype wire
